// File: spi_map_pkg.sv
package spi_map_pkg;

  // **********************************************************************
  // host side address map
  // byte address = {bank, offset}, 32 bits sent msb first
  // **********************************************************************

  localparam logic [7:0]  cmd_write   = 8'h00;    // only command understood

  localparam logic [15:0] bank_points = 16'h1cdd; // vertex buffer, x/y words
  localparam logic [15:0] bank_regs   = 16'h1cde; // color and length regs

  // register offsets inside bank_regs
  localparam logic [1:0] reg_color_msb = 2'd0;
  localparam logic [1:0] reg_color_lsb = 2'd1;
  localparam logic [1:0] reg_len_msb   = 2'd2;
  localparam logic [1:0] reg_len_lsb   = 2'd3;   // write here kicks off a plot

  // word address into the point buffer, byte address is one bit wider
  localparam int unsigned ram_addr_bits = 10;

endpackage

// File: lcd_pkg.sv
package lcd_pkg;

  // **********************************************************************
  // display side widths and codes
  // **********************************************************************

  localparam int unsigned coord_bits = 8;   // low byte of each vertex word
  localparam int unsigned color_bits = 16;  // rgb565
  localparam int unsigned len_bits   = 12;  // length in bytes, 2048 max

  // caset + 4, raset + 4, ramwr + 2
  localparam int unsigned pixel_bytes = 13;

  // st7789 commands used per pixel
  typedef enum logic [7:0] {
    caset = 8'h2a,
    raset = 8'h2b,
    ramwr = 8'h2c
  } lcd_cmd_e;

  typedef enum logic [2:0] {
    draw_idle,
    draw_fetch_x,
    draw_fetch_y,
    draw_step,
    draw_last
  } draw_state_e;

  typedef enum logic [1:0] {
    wr_idle,
    wr_load,
    wr_shift
  } write_state_e;

endpackage

// File: point_bus_if.sv
`timescale 1ns/1ps

// byte writes from the host, 16 bit reads for the drawer
interface point_bus_if;
  logic                                  wr;     // one clk strobe
  logic [spi_map_pkg::ram_addr_bits:0]   waddr;  // byte address
  logic [7:0]                            wdata;
  logic [spi_map_pkg::ram_addr_bits-1:0] raddr;  // word address
  logic [15:0]                           rdata;  // valid one clk after raddr

  modport host (output wr, output waddr, output wdata);

  modport ram (
    input  wr,
    input  waddr,
    input  wdata,
    input  raddr,
    output rdata
  );

  modport reader (output raddr, input rdata);
endinterface

// File: pixel_if.sv
`timescale 1ns/1ps

// one pixel at a time, drawer -> display writer
interface pixel_if;
  logic                            pix;    // strobe, only while busy low
  logic [lcd_pkg::coord_bits-1:0]  x;
  logic [lcd_pkg::coord_bits-1:0]  y;
  logic [lcd_pkg::color_bits-1:0]  color;
  logic                            busy;   // writer still shifting

  modport source (
    output pix,
    output x,
    output y,
    output color,
    input  busy
  );

  modport sink (input pix, input x, input y, input color, output busy);
endinterface

// File: host_spi_slave.sv
`timescale 1ns/1ps

module host_spi_slave (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             spi_csn,
  input  logic                             spi_clk,
  input  logic                             spi_mosi,
  point_bus_if.host                        bus,
  output logic                             plot,
  output logic [lcd_pkg::color_bits-1:0]   color,
  output logic [lcd_pkg::len_bits-1:0]     len
);

  logic [1:0]  csn_sync;
  logic [1:0]  sck_sync;
  logic [1:0]  mosi_sync;
  logic        sck_prev;
  logic        sck_rise;
  logic [2:0]  bit_cnt;    // bits of current byte
  logic [6:0]  shreg;
  logic [7:0]  rx_byte;
  logic [2:0]  phase;      // 0 cmd, 1..4 addr, 5 data
  logic        is_write;
  logic [31:0] addr;
  logic [15:0] bank;

  // rising sck only counted inside a transfer
  assign sck_rise = sck_sync[1] & ~sck_prev & ~csn_sync[1];
  assign rx_byte  = {shreg, mosi_sync[1]};
  assign bank     = addr[31:16];

  // **********************************************************************
  // pin synchronizer
  // **********************************************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      csn_sync  <= 2'b11;
      sck_sync  <= 2'b00;
      mosi_sync <= 2'b00;
      sck_prev  <= 1'b0;
    end else begin
      csn_sync  <= {csn_sync[0], spi_csn};
      sck_sync  <= {sck_sync[0], spi_clk};
      mosi_sync <= {mosi_sync[0], spi_mosi};
      sck_prev  <= sck_sync[1];
    end
  end

  // **********************************************************************
  // byte framing and decode
  // **********************************************************************
  always_ff @(posedge clk) begin
    if (reset) begin
      bus.wr   <= 1'b0;
      plot     <= 1'b0;
      bit_cnt  <= '0;
      phase    <= '0;
      is_write <= 1'b0;
      len      <= '0;
    end else begin
      bus.wr <= 1'b0; // strobes default low
      plot   <= 1'b0;
      if (csn_sync[1]) begin
        bit_cnt <= '0; // deselect restarts framing
        phase   <= '0;
      end else if (sck_rise) begin
        shreg   <= rx_byte[6:0];
        bit_cnt <= bit_cnt + 3'd1;
        if (bit_cnt == 3'd7) begin
          if (phase == 3'd0) begin
            is_write <= (rx_byte == spi_map_pkg::cmd_write);
            phase    <= 3'd1;
          end else if (phase != 3'd5) begin
            addr  <= {addr[23:0], rx_byte}; // address msb first
            phase <= phase + 3'd1;
          end else if (is_write) begin
            addr <= addr + 32'd1; // auto increment
            if (bank == spi_map_pkg::bank_points) begin
              bus.wr    <= 1'b1;
              bus.waddr <= addr[spi_map_pkg::ram_addr_bits:0];
              bus.wdata <= rx_byte;
            end else if (bank == spi_map_pkg::bank_regs) begin
              case (addr[1:0])
                spi_map_pkg::reg_color_msb: color[15:8] <= rx_byte;
                spi_map_pkg::reg_color_lsb: color[7:0]  <= rx_byte;
                spi_map_pkg::reg_len_msb:   len[11:8]   <= rx_byte[3:0];
                spi_map_pkg::reg_len_lsb: begin
                  len[7:0] <= rx_byte; // len lsb starts a plot
                  plot     <= 1'b1;
                end
              endcase
            end
          end
        end
      end
    end
  end

  // host deselects only between whole bytes
  a_csn_on_byte: assert property (@(posedge clk) disable iff (reset)
    $rose(csn_sync[1]) |-> bit_cnt == 3'd0)
    else $error("host deselected in the middle of a byte");

endmodule

// File: point_ram.sv
`timescale 1ns/1ps

module point_ram (
  input logic      clk,
  point_bus_if.ram bus
);

  logic [15:0] mem [0:(1 << spi_map_pkg::ram_addr_bits)-1];
  logic [7:0]  msb_q;                                  // held until its lsb
  logic [spi_map_pkg::ram_addr_bits-1:0] msb_word;     // word of the held msb

  // even byte = msb, odd byte completes the word
  always_ff @(posedge clk) begin
    if (bus.wr) begin
      if (bus.waddr[0]) begin
        mem[bus.waddr[spi_map_pkg::ram_addr_bits:1]] <= {msb_q, bus.wdata};
      end else begin
        msb_q    <= bus.wdata;
        msb_word <= bus.waddr[spi_map_pkg::ram_addr_bits:1];
      end
    end
    bus.rdata <= mem[bus.raddr]; // registered read
  end

  // host must send the msb of the same word first
  a_msb_first: assert property (@(posedge clk)
    bus.wr && bus.waddr[0] |-> msb_word == bus.waddr[spi_map_pkg::ram_addr_bits:1])
    else $error("lsb write at byte %0h without its msb", bus.waddr);

endmodule

// File: polyline_drawer.sv
`timescale 1ns/1ps

module polyline_drawer (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             plot,
  input  logic [lcd_pkg::color_bits-1:0]   color,
  input  logic [lcd_pkg::len_bits-1:0]     len,
  point_bus_if.reader                      ram,
  pixel_if.source                          px,
  output logic                             busy
);

  lcd_pkg::draw_state_e state;

  logic [lcd_pkg::len_bits-3:0]   vidx;        // vertex being loaded
  logic [lcd_pkg::len_bits-3:0]   vlast;       // index of final vertex
  logic                           got_x;
  logic                           first;       // loading vertex 0
  logic                           final_sent;
  logic [lcd_pkg::coord_bits-1:0] cx, cy;      // bresenham position
  logic [lcd_pkg::coord_bits-1:0] ex, ey;      // segment end
  logic [lcd_pkg::coord_bits-1:0] xq, ny;
  logic                           sx_neg, sy_neg;
  logic signed [11:0]             dx, dy, err, e2;
  logic signed [11:0]             adx, ady;
  logic                           x_step, y_step;
  logic                           ready;
  logic [lcd_pkg::color_bits-1:0] color_q;

  assign ready     = !px.busy && !px.pix;      // writer can take a pixel
  assign ram.raddr = {vidx[spi_map_pkg::ram_addr_bits-2:0], state == lcd_pkg::draw_fetch_y};
  assign px.color  = color_q;
  assign ny        = ram.rdata[lcd_pkg::coord_bits-1:0];

  // segment deltas from current point to new vertex
  assign adx = (xq >= cx) ? $signed({4'b0000, xq - cx}) : $signed({4'b0000, cx - xq});
  assign ady = (ny >= cy) ? $signed({4'b0000, ny - cy}) : $signed({4'b0000, cy - ny});

  assign e2     = err <<< 1;
  assign x_step = (e2 >= dy);
  assign y_step = (e2 <= dx);

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= lcd_pkg::draw_idle;
      busy       <= 1'b0;
      px.pix     <= 1'b0;
      vidx       <= '0;
      got_x      <= 1'b0;
      first      <= 1'b0;
      final_sent <= 1'b0;
    end else begin
      px.pix <= 1'b0;
      case (state)
        lcd_pkg::draw_idle: begin
          if (plot && len != '0) begin // len 0 draws nothing
            busy       <= 1'b1;
            color_q    <= color;
            vidx       <= '0;
            if (len[lcd_pkg::len_bits-1:2] == '0) begin
              vlast <= '0;          // partial vertex still draws vertex 0
            end else begin
              vlast <= len[lcd_pkg::len_bits-1:2] - 1'b1;
            end
            first      <= 1'b1;
            final_sent <= 1'b0;
            state      <= lcd_pkg::draw_fetch_x;
          end
        end
        lcd_pkg::draw_fetch_x: begin
          got_x <= 1'b0;          // x word addressed this cycle
          state <= lcd_pkg::draw_fetch_y;
        end
        lcd_pkg::draw_fetch_y: begin
          if (!got_x) begin
            xq    <= ram.rdata[lcd_pkg::coord_bits-1:0];
            got_x <= 1'b1;
          end else if (first) begin
            cx    <= xq;          // vertex 0 is the start point
            cy    <= ny;
            first <= 1'b0;
            if (vlast == '0) begin
              state <= lcd_pkg::draw_last;
            end else begin
              vidx  <= vidx + 1'b1;
              state <= lcd_pkg::draw_fetch_x;
            end
          end else begin
            ex     <= xq;
            ey     <= ny;
            dx     <= adx;
            dy     <= -ady;       // dy kept negative
            err    <= adx - ady;
            sx_neg <= (xq < cx);
            sy_neg <= (ny < cy);
            state  <= lcd_pkg::draw_step;
          end
        end
        lcd_pkg::draw_step: begin
          if (ready) begin
            if (cx == ex && cy == ey) begin // end point left to next segment
              if (vidx == vlast) begin
                state <= lcd_pkg::draw_last;
              end else begin
                vidx  <= vidx + 1'b1;
                state <= lcd_pkg::draw_fetch_x;
              end
            end else begin
              px.pix <= 1'b1;
              px.x   <= cx;
              px.y   <= cy;
              if (x_step) cx <= sx_neg ? cx - 1'b1 : cx + 1'b1;
              if (y_step) cy <= sy_neg ? cy - 1'b1 : cy + 1'b1;
              err <= err + (x_step ? dy : 12'sd0) + (y_step ? dx : 12'sd0);
            end
          end
        end
        default: begin  // draw_last
          if (ready) begin
            if (!final_sent) begin
              px.pix     <= 1'b1; // final vertex only once
              px.x       <= cx;
              px.y       <= cy;
              final_sent <= 1'b1;
            end else begin
              busy  <= 1'b0;      // writer drained
              state <= lcd_pkg::draw_idle;
            end
          end
        end
      endcase
    end
  end

  // writer must be free whenever a pixel is offered
  a_pix_free: assert property (@(posedge clk) disable iff (reset) px.pix |-> !px.busy)
    else $error("pixel offered while writer busy");

endmodule

// File: lcd_pixel_writer.sv
`timescale 1ns/1ps

module lcd_pixel_writer (
  input  logic  clk,
  input  logic  reset,
  pixel_if.sink px,
  output logic  lcd_clk,
  output logic  lcd_mosi,
  output logic  lcd_dc
);

  lcd_pkg::write_state_e state;

  logic [lcd_pkg::coord_bits-1:0] x_q, y_q;
  logic [lcd_pkg::color_bits-1:0] color_q;
  logic [3:0]                     byte_idx;
  logic [3:0]                     sel_idx;   // byte to start next
  logic [2:0]                     bit_cnt;
  logic [6:0]                     sh;        // remaining bits
  logic [7:0]                     cur_byte;
  logic                           cur_dc;

  assign sel_idx = (state == lcd_pkg::wr_load) ? byte_idx : byte_idx + 4'd1;

  // **********************************************************************
  // per pixel byte sequence
  // **********************************************************************
  always_comb begin
    cur_byte = 8'h00;   // zero msb of start/end coords
    cur_dc   = 1'b1;
    case (sel_idx)
      4'd0: begin
        cur_byte = lcd_pkg::caset;
        cur_dc   = 1'b0;
      end
      4'd2, 4'd4: cur_byte = x_q;           // xs = xe
      4'd5: begin
        cur_byte = lcd_pkg::raset;
        cur_dc   = 1'b0;
      end
      4'd7, 4'd9: cur_byte = y_q;           // ys = ye
      4'd10: begin
        cur_byte = lcd_pkg::ramwr;
        cur_dc   = 1'b0;
      end
      4'd11: cur_byte = color_q[15:8];
      4'd12: cur_byte = color_q[7:0];
      default: cur_byte = 8'h00;
    endcase
  end

  // mode 3, mosi moves with falling lcd_clk, 2 clk per bit
  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= lcd_pkg::wr_idle;
      px.busy  <= 1'b0;
      lcd_clk  <= 1'b1;
      lcd_mosi <= 1'b1;
      lcd_dc   <= 1'b0;
      byte_idx <= '0;
      bit_cnt  <= '0;
    end else begin
      case (state)
        lcd_pkg::wr_idle: begin
          if (px.pix) begin
            x_q      <= px.x;
            y_q      <= px.y;
            color_q  <= px.color;
            px.busy  <= 1'b1;
            byte_idx <= '0;
            state    <= lcd_pkg::wr_load;
          end
        end
        lcd_pkg::wr_load: begin      // first byte, first falling edge
          lcd_clk  <= 1'b0;
          lcd_mosi <= cur_byte[7];
          sh       <= cur_byte[6:0];
          lcd_dc   <= cur_dc;
          bit_cnt  <= '0;
          state    <= lcd_pkg::wr_shift;
        end
        default: begin               // wr_shift
          if (!lcd_clk) begin
            lcd_clk <= 1'b1;         // display samples here
          end else if (bit_cnt != 3'd7) begin
            lcd_clk  <= 1'b0;
            lcd_mosi <= sh[6];
            sh       <= {sh[5:0], 1'b0};
            bit_cnt  <= bit_cnt + 3'd1;
          end else if (byte_idx == lcd_pkg::pixel_bytes - 1) begin
            state    <= lcd_pkg::wr_idle;
            px.busy  <= 1'b0;
            lcd_mosi <= 1'b1;        // idle level
          end else begin
            byte_idx <= byte_idx + 4'd1; // next byte, no gap
            lcd_clk  <= 1'b0;
            lcd_mosi <= cur_byte[7];
            sh       <= cur_byte[6:0];
            lcd_dc   <= cur_dc;
            bit_cnt  <= '0;
          end
        end
      endcase
    end
  end

  a_busy_follows_pix: assert property (@(posedge clk) disable iff (reset) px.pix |=> px.busy)
    else $error("busy did not rise after pixel strobe");

endmodule

// File: polyline_top.sv
`timescale 1ns/1ps

module polyline_top (
  input  logic clk,
  input  logic reset,
  input  logic spi_csn,
  input  logic spi_clk,
  input  logic spi_mosi,
  output logic lcd_clk,
  output logic lcd_mosi,
  output logic lcd_dc,
  output logic busy
);

  point_bus_if bus ();  // host and drawer share the vertex buffer
  pixel_if     px ();   // drawer to display writer

  logic                           plot;
  logic [lcd_pkg::color_bits-1:0] color;
  logic [lcd_pkg::len_bits-1:0]   len;

  // **********************************************************************
  // host port, vertex buffer, drawer, display spi
  // **********************************************************************
  host_spi_slave u_host (
    .clk      (clk),
    .reset    (reset),
    .spi_csn  (spi_csn),
    .spi_clk  (spi_clk),
    .spi_mosi (spi_mosi),
    .bus      (bus),
    .plot     (plot),
    .color    (color),
    .len      (len)
  );

  point_ram u_ram (
    .clk (clk),
    .bus (bus)
  );

  polyline_drawer u_drawer (
    .clk   (clk),
    .reset (reset),
    .plot  (plot),
    .color (color),
    .len   (len),
    .ram   (bus),
    .px    (px),
    .busy  (busy)   // high from plot until last pixel is out
  );

  lcd_pixel_writer u_writer (
    .clk      (clk),
    .reset    (reset),
    .px       (px),
    .lcd_clk  (lcd_clk),
    .lcd_mosi (lcd_mosi),
    .lcd_dc   (lcd_dc)
  );

endmodule

// File: polyline_checker.sv
`timescale 1ns/1ps

module polyline_checker (
  input logic clk,
  input logic reset,
  input logic lcd_clk,
  input logic lcd_mosi,
  input logic lcd_dc,
  input logic busy
);

  // st7789 codes, one group of bytes per pixel
  localparam logic [7:0] caset_code = 8'h2a;
  localparam logic [7:0] raset_code = 8'h2b;
  localparam logic [7:0] ramwr_code = 8'h2c;
  localparam int         group_len  = 13;  // cmd + 4, cmd + 4, cmd + 2

  logic [31:0] exp_q [$];               // {x, y, color}
  logic [7:0]  grp [0:group_len-1];     // bytes of the current group
  logic [7:0]  sh;
  logic        byte_dc;                 // dc seen on first bit of byte
  logic        dc_want;
  logic        in_reset_q;
  logic        idle_flagged;
  int          bit_cnt;
  int          byte_cnt;
  int          err_count;
  int          pix_count;

  initial begin
    bit_cnt      = 0;
    byte_cnt     = 0;
    err_count    = 0;
    pix_count    = 0;
    in_reset_q   = 1'b1;
    idle_flagged = 1'b0;
  end

  task automatic expect_pixel(input logic [7:0] x, input logic [7:0] y,
                              input logic [15:0] color);
    exp_q.push_back({x, y, color});
  endtask

  task automatic report_value(input string name, input logic [15:0] got,
                              input logic [15:0] want);
    $display("FAIL %s: got %h expected %h at %0t", name, got, want, $time);
    err_count++;
  endtask

  task automatic report_text(input string what);
    $display("ERROR %s at %0t", what, $time);
    err_count++;
  endtask

  function automatic string byte_name(input int idx);
    case (idx)
      0:       return "caset";
      1, 3:    return "x_msb";
      2, 4:    return "x";
      5:       return "raset";
      6, 8:    return "y_msb";
      7, 9:    return "y";
      10:      return "ramwr";
      11:      return "color_msb";
      default: return "color_lsb";
    endcase
  endfunction

  // **********************************************************************
  // compare one finished group against the head of the queue
  // **********************************************************************
  task automatic check_group;
    logic [31:0] e;
    logic [7:0]  want [0:group_len-1];
    if (exp_q.size() == 0) begin
      report_text($sformatf("pixel x=%h y=%h drawn with none expected", grp[2], grp[7]));
    end else begin
      e        = exp_q.pop_front();
      want[0]  = caset_code;
      want[1]  = 8'h00;        // start column msb
      want[2]  = e[31:24];
      want[3]  = 8'h00;
      want[4]  = e[31:24];     // end column = start
      want[5]  = raset_code;
      want[6]  = 8'h00;
      want[7]  = e[23:16];
      want[8]  = 8'h00;
      want[9]  = e[23:16];
      want[10] = ramwr_code;
      want[11] = e[15:8];      // rgb565 msb first
      want[12] = e[7:0];
      for (int i = 0; i < group_len; i++) begin
        if (grp[i] !== want[i]) report_value(byte_name(i), grp[i], want[i]);
      end
      pix_count++;
    end
  endtask

  task automatic check_drained;
    if (exp_q.size() != 0) begin
      report_text($sformatf("%0d expected pixels never reached the display", exp_q.size()));
      exp_q.delete();
    end
    if (bit_cnt != 0 || byte_cnt != 0) begin
      report_text("display SPI stopped inside a pixel group");
    end
  endtask

  // display samples on rising lcd_clk, msb first
  always @(posedge lcd_clk) begin
    if (!reset) begin
      if (bit_cnt == 0) begin
        byte_dc = lcd_dc;
      end else if (lcd_dc !== byte_dc) begin
        report_text("lcd_dc changed inside a byte");
      end
      sh = {sh[6:0], lcd_mosi};
      bit_cnt++;
      if (bit_cnt == 8) begin
        bit_cnt       = 0;
        grp[byte_cnt] = sh;
        dc_want       = !(byte_cnt == 0 || byte_cnt == 5 || byte_cnt == 10); // cmds low
        if (byte_dc !== dc_want) report_value("lcd_dc", byte_dc, dc_want);
        byte_cnt++;
        if (byte_cnt == group_len) begin
          byte_cnt = 0;
          check_group();
        end
      end
    end
  end

  // idle levels right after reset, and no display traffic while idle
  always @(posedge clk) begin
    if (in_reset_q && !reset) begin
      if (busy !== 1'b0)     report_value("busy", busy, 1'b0);
      if (lcd_clk !== 1'b1)  report_value("lcd_clk", lcd_clk, 1'b1);
      if (lcd_mosi !== 1'b1) report_value("lcd_mosi", lcd_mosi, 1'b1);
      if (lcd_dc !== 1'b0)   report_value("lcd_dc", lcd_dc, 1'b0);
    end
    if (!reset && !busy && !lcd_clk && !idle_flagged) begin
      report_text("display clock running while busy is low");
      idle_flagged = 1'b1;  // once is enough
    end
    in_reset_q = reset;
  end

endmodule

// File: tb_polyline.sv
`timescale 1ns/1ps

module tb_polyline;

  logic             clk;
  logic             reset;
  logic             spi_csn;
  logic             spi_clk;
  logic             spi_mosi;
  logic             lcd_clk;
  logic             lcd_mosi;
  logic             lcd_dc;
  logic             busy;
  logic [31:0]      addr;
  logic [7:0]       xfer_data [0:63];
  logic [7:0]       pix_x;
  logic [7:0]       pix_y;
  logic [15:0]      pix_color;
  logic [8*16-1:0]  kind;        // first token of a line
  logic [8*256-1:0] line;
  logic             watch_armed;
  int               fd;
  int               code;
  int               count;
  int               n_pix;
  int               n_xfer;
  int               limit;

  polyline_top dut (
    .clk      (clk),
    .reset    (reset),
    .spi_csn  (spi_csn),
    .spi_clk  (spi_clk),
    .spi_mosi (spi_mosi),
    .lcd_clk  (lcd_clk),
    .lcd_mosi (lcd_mosi),
    .lcd_dc   (lcd_dc),
    .busy     (busy)
  );

  polyline_checker chk (
    .clk      (clk),
    .reset    (reset),
    .lcd_clk  (lcd_clk),
    .lcd_mosi (lcd_mosi),
    .lcd_dc   (lcd_dc),
    .busy     (busy)
  );

  always #5 clk = ~clk;

  // **********************************************************************
  // host spi, sampled on rising spi_clk, 4 clk per half bit
  // **********************************************************************
  task automatic spi_byte(input logic [7:0] b);
    for (int i = 7; i >= 0; i--) begin
      spi_mosi = b[i];
      repeat (4) @(negedge clk);
      spi_clk = 1'b1;
      repeat (4) @(negedge clk);
      spi_clk = 1'b0;
    end
  endtask

  task automatic spi_write(input logic [31:0] a, input int n);
    @(negedge clk);
    spi_csn = 1'b0;
    repeat (4) @(negedge clk);
    spi_byte(8'h00);                       // write command
    for (int i = 3; i >= 0; i--) begin
      spi_byte(a[8*i +: 8]);               // address msb first
    end
    for (int i = 0; i < n; i++) begin
      spi_byte(xfer_data[i]);
    end
    repeat (4) @(negedge clk);
    spi_csn = 1'b1;
    repeat (8) @(negedge clk);             // plot and busy have landed
  endtask

  task automatic wait_idle;
    while (busy) @(negedge clk);
    chk.check_drained();
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    spi_csn     = 1'b1;
    spi_clk     = 1'b0;
    spi_mosi    = 1'b0;
    n_pix       = 0;
    n_xfer      = 0;
    watch_armed = 1'b0;

    // first pass only sizes the watchdog
    fd = $fopen("polyline_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open polyline_tests.txt");
      $display("Finished with errors");
      $finish;
    end
    while ($fscanf(fd, "%s", kind) == 1) begin
      if (kind == "w") n_xfer++;
      else if (kind == "p") n_pix++;
      code = $fgets(line, fd);
    end
    $fclose(fd);
    limit       = n_pix * 256 + n_xfer * 2000 + 1000;
    watch_armed = 1'b1;

    repeat (10) @(negedge clk);
    reset = 1'b0;
    repeat (4) @(negedge clk);

    fd = $fopen("polyline_tests.txt", "r");
    while ($fscanf(fd, "%s", kind) == 1) begin
      if (kind == "w") begin
        code = $fscanf(fd, "%h %d", addr, count);
        for (int i = 0; i < count; i++) begin
          code = $fscanf(fd, "%h", xfer_data[i]);
        end
        spi_write(addr, count);
      end else if (kind == "p") begin
        code = $fscanf(fd, "%h %h %h", pix_x, pix_y, pix_color);
        chk.expect_pixel(pix_x, pix_y, pix_color);
      end else if (kind == "g") begin
        wait_idle();
      end else begin
        code = $fgets(line, fd);           // comment line
      end
    end
    $fclose(fd);

    repeat (400) @(negedge clk);           // any late bytes show up here
    chk.check_drained();
    $display("pixels checked %0d, errors %0d", chk.pix_count, chk.err_count);
    if (chk.err_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // watchdog, sized from the test file
  initial begin
    wait (watch_armed);
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles, busy never fell", limit);
    $display("Finished with errors");
    $finish;
  end

endmodule

// File: polyline_tests.txt
# w <addr> <n> <n bytes> : one host spi write, n decimal, the rest hex
# p <x> <y> <color> : expected pixel in hex ; g : wait until busy falls
# horizontal, (10,20) to (14,20)
w 1cdd0000 8 00 0a 00 14 00 0e 00 14
p 0a 14 f800
p 0b 14 f800
p 0c 14 f800
p 0d 14 f800
p 0e 14 f800
w 1cde0000 4 f8 00 00 08
g
# steep descending, (30,40) to (32,35)
w 1cdd0000 8 00 1e 00 28 00 20 00 23
p 1e 28 ffe0
p 1e 27 ffe0
p 1f 26 ffe0
p 1f 25 ffe0
p 20 24 ffe0
p 20 23 ffe0
w 1cde0000 4 ff e0 00 08
g
# diagonal, (50,50) to (47,53)
w 1cdd0000 8 00 32 00 32 00 2f 00 35
p 32 32 07ff
p 31 33 07ff
p 30 34 07ff
p 2f 35 07ff
w 1cde0000 4 07 ff 00 08
g
# three vertices, (60,60) (62,60) (62,62), shared vertex once
w 1cdd0000 12 00 3c 00 3c 00 3e 00 3c 00 3e 00 3e
p 3c 3c f81f
p 3d 3c f81f
p 3e 3c f81f
p 3e 3d f81f
p 3e 3e f81f
w 1cde0000 4 f8 1f 00 0c
g
# len 4, vertex 0 only
p 3c 3c 07e0
w 1cde0000 4 07 e0 00 04
g
# stored vertices again, new color
p 3c 3c 001f
p 3d 3c 001f
p 3e 3c 001f
p 3e 3d 001f
p 3e 3e 001f
w 1cde0000 4 00 1f 00 0c
g
# unmapped banks, then replot with len lsb only
w 1cdf0000 4 11 22 33 44
w 00000000 4 55 66 77 88
p 3c 3c 001f
p 3d 3c 001f
p 3e 3c 001f
p 3e 3d 001f
p 3e 3e 001f
w 1cde0003 1 0c
g

// File: sim.f
spi_map_pkg.sv
lcd_pkg.sv
point_bus_if.sv
pixel_if.sv
host_spi_slave.sv
point_ram.sv
polyline_drawer.sv
lcd_pixel_writer.sv
polyline_top.sv
polyline_checker.sv
tb_polyline.sv
